// File: sim.f
rtl/mips_pkg.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/stage_register.sv
rtl/mips_cpu.sv
dv/mips_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= mips_cpu_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mips_cpu_tb.sv
/* Runs one short program per table row and halts each with JR $0.
   Operands are 16-bit immediates sign-extended by ADDIU. Data memory is 64 words at zero. */
`default_nettype none

module mips_cpu_tb import mips_pkg::*; ();

    typedef enum logic [3:0] {
        KIND_ADDU, KIND_SUBU, KIND_AND, KIND_OR, KIND_SLT,
        KIND_ADDIU, KIND_MEMORY, KIND_BRANCH, KIND_FREEZE
    } case_kind_t;

    typedef struct packed {
        case_kind_t kind;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] offset;
    } test_case_t;

    localparam int NUM_CASES = 12;
    localparam int CYCLE_LIMIT = NUM_CASES * 80 + 20;
    localparam reg_addr_t REG_A = 5'd8;
    localparam reg_addr_t REG_B = 5'd9;
    localparam reg_addr_t REG_LOAD = 5'd10;
    localparam reg_addr_t REG_ADDEND = 5'd11;

    logic clk;
    logic reset;
    logic clk_enable;
    logic active;
    logic data_write;
    logic data_read;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    word_t data_writedata;
    word_t data_readdata;

    word_t imem [0:63];
    word_t dmem [0:63];
    word_t imem_offset;
    int write_count;
    int read_count;
    int cycle_count = 0;
    integer seed;
    test_case_t cases [NUM_CASES];

    mips_cpu dut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .clk_enable(clk_enable),
        .instr_address(instr_address),
        .instr_readdata(instr_readdata),
        .data_address(data_address),
        .data_write(data_write),
        .data_read(data_read),
        .data_writedata(data_writedata),
        .data_readdata(data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Outside the program window the core sees no-ops
    assign imem_offset = instr_address - RESET_VECTOR;
    assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : '0;
    assign data_readdata = dmem[data_address[7:2]];

    always @(posedge clk) begin
        if (reset) begin
            write_count <= 0;
            read_count <= 0;
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= '0;
            end
        end else begin
            if (data_write) begin
                dmem[data_address[7:2]] <= data_writedata;
                write_count <= write_count + 1;
            end
            if (data_read) begin
                read_count <= read_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic word_t sign_extend(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    function automatic word_t encode_rtype(input reg_addr_t rs, input reg_addr_t rt,
                                           input reg_addr_t rd, input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t encode_itype(input logic [5:0] opcode, input reg_addr_t rs,
                                           input reg_addr_t rt, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic logic [5:0] funct_of(input case_kind_t kind);
        case (kind)
            KIND_SUBU: return FN_SUBU;
            KIND_AND: return FN_AND;
            KIND_OR: return FN_OR;
            KIND_SLT: return FN_SLT;
            default: return FN_ADDU;
        endcase
    endfunction

    function automatic logic [15:0] random_half();
        return 16'($random(seed));
    endfunction

    // Reference results from the instruction semantics
    function automatic word_t expected_v0(input test_case_t tc);
        word_t x;
        word_t y;
        x = sign_extend(tc.a);
        y = sign_extend(tc.b);
        case (tc.kind)
            KIND_SUBU: return x - y;
            KIND_AND: return x & y;
            KIND_OR: return x | y;
            KIND_SLT: return {31'b0, $signed(x) < $signed(y)};
            KIND_ADDIU: return x + sign_extend(tc.offset);
            KIND_BRANCH: return (x == y) ? '0 : sign_extend(tc.offset);
            default: return x + y;
        endcase
    endfunction

    function automatic word_t expected_writes(input test_case_t tc);
        return (tc.kind == KIND_MEMORY || tc.kind == KIND_FREEZE) ? 32'd1 : 32'd0;
    endfunction

    function automatic word_t expected_reads(input test_case_t tc);
        return (tc.kind == KIND_MEMORY) ? 32'd1 : 32'd0;
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic load_program(input test_case_t tc);
        word_t words [$];
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        words.push_back(encode_itype(OP_ADDIU, 5'd0, REG_A, tc.a));
        case (tc.kind)
            KIND_ADDIU: begin
                words.push_back(encode_itype(OP_ADDIU, REG_A, V0_INDEX, tc.offset));
            end
            KIND_MEMORY: begin
                words.push_back(encode_itype(OP_ADDIU, 5'd0, REG_B, tc.offset));
                words.push_back(encode_itype(OP_ADDIU, 5'd0, REG_ADDEND, tc.b));
                words.push_back(encode_itype(OP_SW, REG_B, REG_A, 16'd0));
                words.push_back(encode_itype(OP_LW, REG_B, REG_LOAD, 16'd0));
                words.push_back(encode_rtype(REG_LOAD, REG_ADDEND, V0_INDEX, FN_ADDU));
            end
            KIND_BRANCH: begin
                words.push_back(encode_itype(OP_ADDIU, 5'd0, REG_B, tc.b));
                words.push_back(encode_itype(OP_BEQ, REG_A, REG_B, 16'd1));
                words.push_back(encode_itype(OP_ADDIU, 5'd0, V0_INDEX, tc.offset));
            end
            KIND_FREEZE: begin
                words.push_back(encode_itype(OP_ADDIU, 5'd0, REG_B, tc.b));
                words.push_back(encode_itype(OP_SW, 5'd0, REG_A, 16'd32));
                words.push_back(encode_rtype(REG_A, REG_B, V0_INDEX, FN_ADDU));
            end
            default: begin
                words.push_back(encode_itype(OP_ADDIU, 5'd0, REG_B, tc.b));
                words.push_back(encode_rtype(REG_A, REG_B, V0_INDEX, funct_of(tc.kind)));
            end
        endcase
        words.push_back(encode_rtype(5'd0, 5'd0, 5'd0, FN_JR));
        // Must never execute once the JR halts the core
        words.push_back(encode_itype(OP_ADDIU, V0_INDEX, V0_INDEX, 16'd1));
        words.push_back(encode_itype(OP_SW, 5'd0, V0_INDEX, 16'd4));
        foreach (words[i]) begin
            imem[i] = words[i];
        end
    endtask

    task automatic run_case(input test_case_t tc);
        word_t v0_at_halt;
        int writes_at_halt;
        load_program(tc);
        @(posedge clk);
        reset <= 1'b1;
        clk_enable <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag(active, 1'b1, "active in reset");
        check_flag(data_write, 1'b0, "data_write in reset");
        check_flag(data_read, 1'b0, "data_read in reset");
        check_word(instr_address, RESET_VECTOR, "instr_address in reset");
        @(posedge clk);
        reset <= 1'b0;
        if (tc.kind == KIND_FREEZE) begin
            // Freeze while the SW sits in the memory stage
            repeat (5) @(posedge clk);
            clk_enable <= 1'b0;
            repeat (tc.offset) @(posedge clk);
            clk_enable <= 1'b1;
        end
        while (active) begin
            @(negedge clk);
        end
        // Drain what is still in flight
        repeat (5) @(negedge clk);
        check_word(register_v0, expected_v0(tc), "register_v0");
        check_word(word_t'(write_count), expected_writes(tc), "memory write count");
        check_word(word_t'(read_count), expected_reads(tc), "memory read count");
        if (tc.kind == KIND_MEMORY) begin
            check_word(dmem[tc.offset[7:2]], sign_extend(tc.a), "stored word");
        end
        if (tc.kind == KIND_FREEZE) begin
            check_word(dmem[8], sign_extend(tc.a), "stored word across freeze");
        end
        v0_at_halt = register_v0;
        writes_at_halt = write_count;
        repeat (10) @(negedge clk);
        check_flag(active, 1'b0, "active after halt");
        check_word(register_v0, v0_at_halt, "register_v0 after halt");
        check_word(word_t'(write_count), word_t'(writes_at_halt), "write count after halt");
    endtask

    initial begin
        logic [15:0] shared;
        seed = 80403;
        reset = 1'b1;
        clk_enable = 1'b0;
        shared = random_half();
        cases[0] = '{KIND_ADDU, 16'd5, 16'd7, 16'd0};
        cases[1] = '{KIND_SUBU, 16'd3, 16'd10, 16'd0};
        cases[2] = '{KIND_AND, random_half(), random_half(), 16'd0};
        cases[3] = '{KIND_OR, random_half(), random_half(), 16'd0};
        cases[4] = '{KIND_SLT, 16'hFFFC, 16'd3, 16'd0};
        cases[5] = '{KIND_SLT, 16'd3, 16'hFFFC, 16'd0};
        cases[6] = '{KIND_ADDIU, random_half(), 16'd0, random_half()};
        cases[7] = '{KIND_MEMORY, random_half(), random_half(), 16'h0010};
        // Equal operands take the branch, unequal ones fall through
        cases[8] = '{KIND_BRANCH, shared, shared, 16'h0055};
        cases[9] = '{KIND_BRANCH, shared, shared ^ 16'h0100, 16'hFF80};
        cases[10] = '{KIND_FREEZE, random_half(), random_half(),
                      16'({$random(seed)} % 32'd8 + 32'd1)};
        cases[11] = '{KIND_ADDU, random_half(), random_half(), 16'd0};
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(cases[i]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mips_cpu.sv
/* Five-stage MIPS core on a Harvard bus, no delay slots. clk_enable low
   freezes all state. A JR to address zero halts fetch and drops active. */
`default_nettype none

module mips_cpu import mips_pkg::*; (
    input logic clk,
    input logic reset,
    output logic active,
    output word_t register_v0,
    input logic clk_enable,
    output word_t instr_address,
    input word_t instr_readdata,
    output word_t data_address,
    output logic data_write,
    output logic data_read,
    output word_t data_writedata,
    input word_t data_readdata
);

    word_t pc;
    word_t pc_plus_four;
    word_t pc_next;

    fetch_decode_t fetch_decode_next;
    fetch_decode_t fetch_decode;
    decode_execute_t decode_execute_next;
    decode_execute_t decode_execute;
    execute_memory_t execute_memory_next;
    execute_memory_t execute_memory;
    memory_writeback_t memory_writeback_next;
    memory_writeback_t memory_writeback;

    logic register_write_decode;
    logic memory_to_register_decode;
    logic memory_write_decode;
    logic alu_src_imm_decode;
    logic destination_rd_decode;
    logic branch_decode;
    logic jump_decode;
    alu_op_t alu_op_decode;
    reg_addr_t rs_decode;
    reg_addr_t rt_decode;
    reg_addr_t rd_decode;
    word_t read_data_1;
    word_t read_data_2;
    word_t compare_a;
    word_t compare_b;
    word_t sign_imm;
    word_t branch_target;
    logic taken;
    logic halt_decode;

    word_t source_a;
    word_t store_data;
    word_t alu_result;
    word_t result_writeback;

    logic stall_fetch;
    logic stall_decode;
    logic flush_execute;
    logic forward_a_decode;
    logic forward_b_decode;
    logic [1:0] forward_a_execute;
    logic [1:0] forward_b_execute;

    // Fetch
    assign instr_address = pc;
    assign pc_plus_four = pc + 32'd4;
    assign pc_next = taken ? (jump_decode ? compare_a : branch_target) : pc_plus_four;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
            active <= 1'b1;
        end else if (clk_enable) begin
            if (active && !stall_fetch && !halt_decode) begin
                pc <= pc_next;
            end
            if (halt_decode && !stall_decode) begin
                active <= 1'b0;
            end
        end
    end

    // After halt only no-ops enter decode
    assign fetch_decode_next = active ? '{instruction: instr_readdata, pc_plus_four: pc_plus_four}
                                      : '0;

    stage_register #(.payload_t(fetch_decode_t)) f_d (
        .clk(clk),
        .reset(reset),
        .enable(clk_enable && !stall_decode),
        .clear(taken && !stall_decode),
        .d(fetch_decode_next),
        .q(fetch_decode)
    );

    // Decode
    assign rs_decode = fetch_decode.instruction[25:21];
    assign rt_decode = fetch_decode.instruction[20:16];
    assign rd_decode = fetch_decode.instruction[15:11];
    assign sign_imm = {{16{fetch_decode.instruction[15]}}, fetch_decode.instruction[15:0]};
    assign branch_target = fetch_decode.pc_plus_four + {sign_imm[29:0], 2'b00};

    control_unit control (
        .instruction(fetch_decode.instruction),
        .register_write(register_write_decode),
        .memory_to_register(memory_to_register_decode),
        .memory_write(memory_write_decode),
        .alu_src_imm(alu_src_imm_decode),
        .destination_rd(destination_rd_decode),
        .branch(branch_decode),
        .jump_register(jump_decode),
        .alu_op(alu_op_decode)
    );

    register_file registers (
        .clk(clk),
        .reset(reset),
        .write_enable(memory_writeback.register_write && clk_enable),
        .write_address(memory_writeback.write_register),
        .write_data(result_writeback),
        .read_address_1(rs_decode),
        .read_address_2(rt_decode),
        .read_data_1(read_data_1),
        .read_data_2(read_data_2),
        .v0(register_v0)
    );

    assign compare_a = forward_a_decode ? execute_memory.alu_result : read_data_1;
    assign compare_b = forward_b_decode ? execute_memory.alu_result : read_data_2;
    assign taken = jump_decode || (branch_decode && compare_a == compare_b);
    assign halt_decode = jump_decode && compare_a == '0;

    assign decode_execute_next = '{
        register_write: register_write_decode,
        memory_to_register: memory_to_register_decode,
        memory_write: memory_write_decode,
        alu_src_imm: alu_src_imm_decode,
        alu_op: alu_op_decode,
        rs: rs_decode,
        rt: rt_decode,
        write_register: destination_rd_decode ? rd_decode : rt_decode,
        operand_a: read_data_1,
        operand_b: read_data_2,
        immediate: sign_imm
    };

    stage_register #(.payload_t(decode_execute_t)) d_e (
        .clk(clk),
        .reset(reset),
        .enable(clk_enable),
        .clear(flush_execute),
        .d(decode_execute_next),
        .q(decode_execute)
    );

    // Execute
    always_comb begin
        case (forward_a_execute)
            2'b10: source_a = execute_memory.alu_result;
            2'b01: source_a = result_writeback;
            default: source_a = decode_execute.operand_a;
        endcase
        case (forward_b_execute)
            2'b10: store_data = execute_memory.alu_result;
            2'b01: store_data = result_writeback;
            default: store_data = decode_execute.operand_b;
        endcase
    end

    alu alu_execute (
        .alu_op(decode_execute.alu_op),
        .operand_a(source_a),
        .operand_b(decode_execute.alu_src_imm ? decode_execute.immediate : store_data),
        .result(alu_result)
    );

    assign execute_memory_next = '{
        register_write: decode_execute.register_write,
        memory_to_register: decode_execute.memory_to_register,
        memory_write: decode_execute.memory_write,
        alu_result: alu_result,
        store_data: store_data,
        write_register: decode_execute.write_register
    };

    stage_register #(.payload_t(execute_memory_t)) e_m (
        .clk(clk),
        .reset(reset),
        .enable(clk_enable),
        .clear(1'b0),
        .d(execute_memory_next),
        .q(execute_memory)
    );

    // Memory
    assign data_address = execute_memory.alu_result;
    assign data_writedata = execute_memory.store_data;
    assign data_write = execute_memory.memory_write && clk_enable;
    assign data_read = execute_memory.memory_to_register;

    assign memory_writeback_next = '{
        register_write: execute_memory.register_write,
        memory_to_register: execute_memory.memory_to_register,
        alu_result: execute_memory.alu_result,
        read_data: data_readdata,
        write_register: execute_memory.write_register
    };

    stage_register #(.payload_t(memory_writeback_t)) m_w (
        .clk(clk),
        .reset(reset),
        .enable(clk_enable),
        .clear(1'b0),
        .d(memory_writeback_next),
        .q(memory_writeback)
    );

    // Writeback
    assign result_writeback = memory_writeback.memory_to_register ? memory_writeback.read_data
                                                                  : memory_writeback.alu_result;

    hazard_unit hazards (
        .branch_decode(branch_decode),
        .jump_decode(jump_decode),
        .rs_decode(rs_decode),
        .rt_decode(rt_decode),
        .rs_execute(decode_execute.rs),
        .rt_execute(decode_execute.rt),
        .write_register_execute(decode_execute.write_register),
        .register_write_execute(decode_execute.register_write),
        .memory_to_register_execute(decode_execute.memory_to_register),
        .write_register_memory(execute_memory.write_register),
        .register_write_memory(execute_memory.register_write),
        .memory_to_register_memory(execute_memory.memory_to_register),
        .write_register_writeback(memory_writeback.write_register),
        .register_write_writeback(memory_writeback.register_write),
        .stall_fetch(stall_fetch),
        .stall_decode(stall_decode),
        .flush_execute(flush_execute),
        .forward_a_decode(forward_a_decode),
        .forward_b_decode(forward_b_decode),
        .forward_a_execute(forward_a_execute),
        .forward_b_execute(forward_b_execute)
    );

endmodule

`default_nettype wire

// File: rtl/stage_register.sv
/* Pipeline register for any packed payload. Clear only acts together with
   enable, so a frozen pipeline also holds its bubbles. */
`default_nettype none

module stage_register #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic clear,
    input payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (enable) begin
            if (clear) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
/* Forwarding and stall logic. Execute selects: 00 register file, 01 writeback,
   10 memory. Decode only forwards ALU results from memory; loads stall instead. */
`default_nettype none

module hazard_unit import mips_pkg::*; (
    input logic branch_decode,
    input logic jump_decode,
    input reg_addr_t rs_decode,
    input reg_addr_t rt_decode,
    input reg_addr_t rs_execute,
    input reg_addr_t rt_execute,
    input reg_addr_t write_register_execute,
    input logic register_write_execute,
    input logic memory_to_register_execute,
    input reg_addr_t write_register_memory,
    input logic register_write_memory,
    input logic memory_to_register_memory,
    input reg_addr_t write_register_writeback,
    input logic register_write_writeback,
    output logic stall_fetch,
    output logic stall_decode,
    output logic flush_execute,
    output logic forward_a_decode,
    output logic forward_b_decode,
    output logic [1:0] forward_a_execute,
    output logic [1:0] forward_b_execute
);

    logic load_use;
    logic execute_conflict;
    logic memory_conflict;
    logic branch_stall;
    logic stall;

    // Memory stage wins over writeback, it holds the younger result
    function automatic logic [1:0] select_source(reg_addr_t source);
        if (source != '0 && register_write_memory && write_register_memory == source) begin
            return 2'b10;
        end
        if (source != '0 && register_write_writeback && write_register_writeback == source) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    assign forward_a_execute = select_source(rs_execute);
    assign forward_b_execute = select_source(rt_execute);

    assign forward_a_decode = register_write_memory && rs_decode != '0
        && write_register_memory == rs_decode;
    assign forward_b_decode = register_write_memory && rt_decode != '0
        && write_register_memory == rt_decode;

    assign load_use = memory_to_register_execute && write_register_execute != '0
        && (write_register_execute == rs_decode || write_register_execute == rt_decode);

    // BEQ compares rs and rt, JR only reads rs
    assign execute_conflict = register_write_execute && write_register_execute != '0
        && (write_register_execute == rs_decode
            || (branch_decode && write_register_execute == rt_decode));
    assign memory_conflict = memory_to_register_memory && write_register_memory != '0
        && (write_register_memory == rs_decode
            || (branch_decode && write_register_memory == rt_decode));
    assign branch_stall = (branch_decode || jump_decode) && (execute_conflict || memory_conflict);

    assign stall = load_use || branch_stall;
    assign stall_fetch = stall;
    assign stall_decode = stall;
    assign flush_execute = stall;

endmodule

`default_nettype wire

// File: rtl/alu.sv
/* Combinational ALU. No overflow trap: ADDU and SUBU wrap. */
`default_nettype none

module alu import mips_pkg::*; (
    input alu_op_t alu_op,
    input word_t operand_a,
    input word_t operand_b,
    output word_t result
);

    always_comb begin
        case (alu_op)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR: result = operand_a | operand_b;
            // Signed compare
            ALU_SLT: result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
/* Decode of the supported subset. Anything else, including the all-zero
   word, becomes a no-op with no register or memory write. */
`default_nettype none

module control_unit import mips_pkg::*; (
    input word_t instruction,
    output logic register_write,
    output logic memory_to_register,
    output logic memory_write,
    output logic alu_src_imm,
    output logic destination_rd,
    output logic branch,
    output logic jump_register,
    output alu_op_t alu_op
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];

    always_comb begin
        register_write = 1'b0;
        memory_to_register = 1'b0;
        memory_write = 1'b0;
        alu_src_imm = 1'b0;
        destination_rd = 1'b0;
        branch = 1'b0;
        jump_register = 1'b0;
        alu_op = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                destination_rd = 1'b1;
                register_write = funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT};
                jump_register = (funct == FN_JR);
                case (funct)
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND: alu_op = ALU_AND;
                    FN_OR: alu_op = ALU_OR;
                    FN_SLT: alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_ADDIU: begin
                register_write = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LW: begin
                register_write = 1'b1;
                memory_to_register = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_SW: begin
                memory_write = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_BEQ: begin
                branch = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
/* 32 x 32 register file, $0 reads as zero. A write is visible on the read
   ports in the same cycle, so decode sees the value writeback produces. */
`default_nettype none

module register_file import mips_pkg::*; (
    input logic clk,
    input logic reset,
    input logic write_enable,
    input reg_addr_t write_address,
    input word_t write_data,
    input reg_addr_t read_address_1,
    input reg_addr_t read_address_2,
    output word_t read_data_1,
    output word_t read_data_2,
    output word_t v0
);

    word_t registers [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            registers[write_address] <= write_data;
        end
    end

    always_comb begin
        if (read_address_1 == '0) begin
            read_data_1 = '0;
        end else if (write_enable && write_address == read_address_1) begin
            read_data_1 = write_data;
        end else begin
            read_data_1 = registers[read_address_1];
        end
    end

    always_comb begin
        if (read_address_2 == '0) begin
            read_data_2 = '0;
        end else if (write_enable && write_address == read_address_2) begin
            read_data_2 = write_data;
        end else begin
            read_data_2 = registers[read_address_2];
        end
    end

    assign v0 = registers[V0_INDEX];

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
/* Shared types, encodings and pipeline payloads of the five-stage MIPS core.
   An all-zero payload is a bubble with every write enable low. */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2B;
    localparam logic [5:0] OP_BEQ = 6'h04;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2A;
    localparam logic [5:0] FN_JR = 6'h08;

    localparam word_t RESET_VECTOR = 32'hBFC00000;
    localparam reg_addr_t V0_INDEX = 5'd2;

    typedef struct packed {
        word_t instruction;
        word_t pc_plus_four;
    } fetch_decode_t;

    typedef struct packed {
        logic register_write;
        logic memory_to_register;
        logic memory_write;
        logic alu_src_imm;
        alu_op_t alu_op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t write_register;
        word_t operand_a;
        word_t operand_b;
        word_t immediate;
    } decode_execute_t;

    typedef struct packed {
        logic register_write;
        logic memory_to_register;
        logic memory_write;
        word_t alu_result;
        word_t store_data;
        reg_addr_t write_register;
    } execute_memory_t;

    typedef struct packed {
        logic register_write;
        logic memory_to_register;
        word_t alu_result;
        word_t read_data;
        reg_addr_t write_register;
    } memory_writeback_t;

endpackage

`default_nettype wire
